//--- sources.f
rtl/cache_pkg.sv
rtl/cache_arbiter.sv
rtl/icache.sv
rtl/dcache.sv
rtl/cache_subsystem.sv
dv/pmem_model.sv
dv/cache_subsystem_tb.sv

//--- dv/cache_subsystem_tb.sv
`timescale 1ns/1ps

module cache_subsystem_tb;
    import cache_pkg::*;

    localparam int mem_latency    = 5;
    localparam int total_requests = 200 + 300 + 36 + 400;
    localparam int miss_cycles    = 4 * (mem_latency + 3);   // victim, refill and a rival line.
    localparam int cycle_limit    = total_requests * miss_cycles + 100;

    logic        clk = 1'b0;
    logic        reset;
    rv32i_word   icache_addr;
    logic        icache_read;
    rv32i_word   icache_rdata;
    logic        icache_resp;
    dcache_req_t dcache_req;
    rv32i_word   dcache_rdata;
    logic        dcache_resp;
    line_req_t   mem_req;
    cacheline    mem_rdata;
    logic        mem_resp;

    logic [7:0]  shadow [2048];                     // architectural byte contents.
    logic [31:0] lcg_state = 32'h8417abf4;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;

    cache_subsystem #(.num_sets(4)) dut (
        .clk(clk), .reset(reset),
        .icache_addr(icache_addr), .icache_read(icache_read),
        .icache_rdata(icache_rdata), .icache_resp(icache_resp),
        .dcache_req(dcache_req), .dcache_rdata(dcache_rdata), .dcache_resp(dcache_resp),
        .mem_req(mem_req), .mem_rdata(mem_rdata), .mem_resp(mem_resp)
    );

    pmem_model #(.latency(mem_latency), .mem_bytes(2048)) pmem (
        .clk(clk), .reset(reset),
        .mem_req(mem_req), .mem_rdata(mem_rdata), .mem_resp(mem_resp)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    initial begin
        wait (cycles >= cycle_limit);
        $display("run stopped after %0d cycles, a request never completed", cycles);
        $display("Errors found");
        $finish;
    end

    function rv32i_word lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [7:0] initial_byte(input logic [31:0] a);
        logic [7:0] hi;
        hi = a[15:8] ^ a[23:16] ^ a[31:24];
        return a[7:0] ^ (hi * 8'd37) ^ 8'h5a;
    endfunction

    function automatic rv32i_word shadow_word(input rv32i_word a);
        return {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};   // little endian.
    endfunction

    task automatic check_quiet(input string when_seen);
        checks++;
        assert (icache_resp === 1'b0 && dcache_resp === 1'b0 && mem_req.read === 1'b0
                && mem_req.write === 1'b0) else begin
            $display("a response or memory request was active %s", when_seen);
            errors++;
        end
    endtask

    task automatic fetch_check(input rv32i_word a);
        rv32i_word expected;
        expected = shadow_word(a);
        @(negedge clk);
        icache_addr = a;
        icache_read = 1'b1;
        @(negedge clk);
        while (!icache_resp) begin
            @(negedge clk);
        end
        icache_read = 1'b0;
        checks++;
        assert (icache_rdata === expected) else begin
            $display("ERROR icache_rdata addr=%h got=%h expected=%h", a, icache_rdata, expected);
            errors++;
        end
    endtask

    task automatic data_access(input logic is_store, input rv32i_word a, input byte_mask m,
                               input rv32i_word wd);
        rv32i_word expected;
        @(negedge clk);
        dcache_req.addr  = a;
        dcache_req.read  = !is_store;
        dcache_req.write = is_store;
        dcache_req.wmask = m;
        dcache_req.wdata = wd;
        @(negedge clk);
        while (!dcache_resp) begin
            @(negedge clk);
        end
        dcache_req.read  = 1'b0;
        dcache_req.write = 1'b0;
        if (is_store) begin
            for (int i = 0; i < 4; i++) begin
                if (m[i]) begin
                    shadow[a + i] = wd[i * 8 +: 8];     // completed store.
                end
            end
        end else begin
            expected = shadow_word(a);
            checks++;
            assert (dcache_rdata === expected) else begin
                $display("ERROR dcache_rdata addr=%h got=%h expected=%h", a, dcache_rdata,
                         expected);
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int requests, input int base);
        $display("test %s: %0d requests, %0d errors", name, requests, errors - base);
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            assert (!(mem_req.read === 1'b1 && mem_req.write === 1'b1)) else begin
                $display("memory port had read and write high in the same cycle");
                errors++;
            end
        end
    end

    initial begin
        rv32i_word r;
        rv32i_word r2;
        cacheline  expected_line;
        int        base;

        reset       = 1'b1;
        icache_addr = '0;
        icache_read = 1'b0;
        dcache_req  = '0;
        for (int a = 0; a < 2048; a++) begin
            shadow[a] = initial_byte(a);
        end

        base = errors;
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_quiet("during reset");
        end
        reset = 1'b0;
        @(negedge clk);
        check_quiet("in the cycle after reset");
        report_test("reset", 0, base);

        base = errors;
        for (int i = 0; i < 200; i++) begin
            r = lcg_next();
            fetch_check({22'd0, r[21:14], 2'b00});
        end
        report_test("fetch", 200, base);

        base = errors;
        for (int i = 0; i < 300; i++) begin
            r  = lcg_next();
            r2 = lcg_next();
            data_access(r[31], {22'd0, r[21:14], 2'b00}, r[27:24], r2);
        end
        report_test("load_store", 300, base);

        // fetches stay in the upper KB, which no store touches.
        base = errors;
        for (int i = 0; i < 200; i++) begin
            r  = lcg_next();
            r2 = lcg_next();
            fork
                fetch_check({21'd0, 1'b1, r[21:14], 2'b00});
                data_access(r2[31], {22'd0, r2[21:14], 2'b00}, r2[27:24], lcg_next());
            join
        end
        report_test("concurrent", 400, base);

        // consecutive stores share a set with different tags.
        base = errors;
        for (int k = 0; k < 32; k++) begin
            r = lcg_next();
            data_access(1'b1, {22'd0, k[2:0], k[4:3], r[21:19], 2'b00}, r[27:24] | 4'b0001,
                        lcg_next());
        end
        for (int s = 0; s < 4; s++) begin
            data_access(1'b0, 32'h400 + s * 32, 4'h0, 32'h0);   // evict every set.
        end
        for (int l = 0; l < 32; l++) begin
            for (int b = 0; b < 32; b++) begin
                expected_line[b * 8 +: 8] = shadow[l * 32 + b];
            end
            checks++;
            assert (pmem.lines[l] === expected_line) else begin
                $display("ERROR pmem.lines[%0d] got=%h expected=%h", l, pmem.lines[l],
                         expected_line);
                errors++;
            end
        end
        report_test("write_back", 36, base);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- dv/pmem_model.sv
`timescale 1ns/1ps

module pmem_model #(
    parameter int latency   = 5,
    parameter int mem_bytes = 2048
) (
    input  logic                 clk,
    input  logic                 reset,
    input  cache_pkg::line_req_t mem_req,
    output cache_pkg::cacheline  mem_rdata,
    output logic                 mem_resp
);
    import cache_pkg::*;

    localparam int num_lines = mem_bytes / 32;
    localparam int line_bits = $clog2(num_lines);

    cacheline             lines [num_lines];   // byte k of a line sits at bits 8k.
    int                   count;
    logic [line_bits-1:0] line_idx;

    assign line_idx = mem_req.addr[offset_bits +: line_bits];

    // fill pattern folds every address byte into the data.
    function automatic logic [7:0] pattern_byte(input logic [31:0] a);
        logic [7:0] hi;
        hi = a[15:8] ^ a[23:16] ^ a[31:24];
        return a[7:0] ^ (hi * 8'd37) ^ 8'h5a;
    endfunction

    initial begin
        mem_rdata = '0;
        mem_resp  = 1'b0;
        for (int l = 0; l < num_lines; l++) begin
            for (int b = 0; b < 32; b++) begin
                lines[l][b * 8 +: 8] = pattern_byte(l * 32 + b);
            end
        end
    end

    // requests are levels, so the resp cycle itself is not counted again.
    always @(posedge clk) begin
        if (reset) begin
            count    <= 0;
            mem_resp <= 1'b0;
        end else begin
            mem_resp <= 1'b0;
            if ((mem_req.read || mem_req.write) && !mem_resp) begin
                if (count == latency - 1) begin
                    count    <= 0;
                    mem_resp <= 1'b1;
                    if (mem_req.write) begin
                        lines[line_idx] <= mem_req.data;     // write-back lands here.
                    end else begin
                        mem_rdata <= lines[line_idx];
                    end
                end else begin
                    count <= count + 1;
                end
            end
        end
    end

endmodule

//--- rtl/cache_subsystem.sv
`timescale 1ns/1ps

module cache_subsystem #(
    parameter int num_sets = 16
) (
    input  logic                   clk,
    input  logic                   reset,

    input  cache_pkg::rv32i_word   icache_addr,
    input  logic                   icache_read,
    output cache_pkg::rv32i_word   icache_rdata,
    output logic                   icache_resp,

    input  cache_pkg::dcache_req_t dcache_req,
    output cache_pkg::rv32i_word   dcache_rdata,
    output logic                   dcache_resp,

    output cache_pkg::line_req_t   mem_req,
    input  cache_pkg::cacheline    mem_rdata,
    input  logic                   mem_resp
);
    import cache_pkg::*;

    line_req_t icache_mem_req;
    line_req_t dcache_mem_req;
    cacheline  icache_mem_rdata;
    cacheline  dcache_mem_rdata;
    logic      icache_mem_resp;
    logic      dcache_mem_resp;

    icache #(
        .num_sets(num_sets)
    ) icache_unit (
        .clk      (clk),
        .reset    (reset),
        .addr     (icache_addr),
        .read     (icache_read),
        .rdata    (icache_rdata),
        .resp     (icache_resp),
        .mem_req  (icache_mem_req),
        .mem_rdata(icache_mem_rdata),
        .mem_resp (icache_mem_resp)
    );

    dcache #(
        .num_sets(num_sets)
    ) dcache_unit (
        .clk      (clk),
        .reset    (reset),
        .req      (dcache_req),
        .rdata    (dcache_rdata),
        .resp     (dcache_resp),
        .mem_req  (dcache_mem_req),
        .mem_rdata(dcache_mem_rdata),
        .mem_resp (dcache_mem_resp)
    );

    cache_arbiter arbiter (
        .clk             (clk),
        .reset           (reset),
        .icache_mem_req  (icache_mem_req),
        .icache_mem_rdata(icache_mem_rdata),
        .icache_mem_resp (icache_mem_resp),
        .dcache_mem_req  (dcache_mem_req),
        .dcache_mem_rdata(dcache_mem_rdata),
        .dcache_mem_resp (dcache_mem_resp),
        .mem_req         (mem_req),
        .mem_rdata       (mem_rdata),
        .mem_resp        (mem_resp)
    );

endmodule

//--- rtl/dcache.sv
`timescale 1ns/1ps

module dcache #(
    parameter int num_sets = 16
) (
    input  logic                   clk,
    input  logic                   reset,

    input  cache_pkg::dcache_req_t req,
    output cache_pkg::rv32i_word   rdata,
    output logic                   resp,

    output cache_pkg::line_req_t   mem_req,
    input  cache_pkg::cacheline    mem_rdata,
    input  logic                   mem_resp
);
    import cache_pkg::*;

    localparam int idx_bits = $clog2(num_sets);
    localparam int tag_bits = 32 - offset_bits - idx_bits;

    cache_state_e        state;
    logic [tag_bits-1:0] tag_arr [num_sets];
    cacheline            data_arr [num_sets];
    logic [num_sets-1:0] valid;
    logic [num_sets-1:0] dirty;

    logic [tag_bits-1:0] tag;
    logic [idx_bits-1:0] index;
    logic [2:0]          word_sel;
    logic                active;
    logic                hit;
    logic                store_hit;
    cacheline            merged_line;

    assign tag       = req.addr[31 -: tag_bits];
    assign index     = req.addr[offset_bits +: idx_bits];
    assign word_sel  = req.addr[4:2];
    assign active    = (req.read || req.write) && !resp;
    assign hit       = valid[index] && (tag_arr[index] == tag);
    assign store_hit = (state == lookup) && active && hit && req.write;

    // store data merged into the resident line, lane by lane
    always_comb begin
        merged_line = data_arr[index];
        for (int i = 0; i < 4; i++) begin
            if (req.wmask[i]) begin
                merged_line[{word_sel, 5'b0} + i * 8 +: 8] = req.wdata[i * 8 +: 8];
            end
        end
    end

    always_comb begin
        mem_req = '0;
        case (state)
            write_back: begin
                // the victim goes back to the address of its own tag
                mem_req.addr  = {tag_arr[index], index, {offset_bits{1'b0}}};
                mem_req.write = 1'b1;
                mem_req.data  = data_arr[index];
            end
            refill: begin
                mem_req.addr = {req.addr[31:offset_bits], {offset_bits{1'b0}}};
                mem_req.read = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= lookup;
            valid <= '0;
            dirty <= '0;
            resp  <= 1'b0;
        end else begin
            resp <= 1'b0;
            case (state)
                lookup: begin
                    if (active) begin
                        if (hit) begin
                            resp <= 1'b1;
                            if (req.write) begin
                                dirty[index] <= 1'b1;
                            end
                        end else if (valid[index] && dirty[index]) begin
                            state <= write_back;      // evict before refilling.
                        end else begin
                            state <= refill;
                        end
                    end
                end
                write_back: begin
                    if (mem_resp) begin
                        dirty[index] <= 1'b0;
                        state        <= refill;
                    end
                end
                refill: begin
                    if (mem_resp) begin
                        valid[index] <= 1'b1;
                        dirty[index] <= 1'b0;
                        state        <= lookup;
                    end
                end
                default: state <= lookup;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == refill && mem_resp) begin
            tag_arr[index]  <= tag;
            data_arr[index] <= mem_rdata;
        end else if (store_hit) begin
            data_arr[index] <= merged_line;
        end
        if (state == lookup && active && hit && req.read) begin
            rdata <= data_arr[index][{word_sel, 5'b0} +: 32];   // load word.
        end
    end

endmodule

//--- rtl/icache.sv
`timescale 1ns/1ps

module icache #(
    parameter int num_sets = 16
) (
    input  logic                 clk,
    input  logic                 reset,

    input  cache_pkg::rv32i_word addr,
    input  logic                 read,
    output cache_pkg::rv32i_word rdata,
    output logic                 resp,

    output cache_pkg::line_req_t mem_req,
    input  cache_pkg::cacheline  mem_rdata,
    input  logic                 mem_resp
);
    import cache_pkg::*;

    localparam int idx_bits = $clog2(num_sets);
    localparam int tag_bits = 32 - offset_bits - idx_bits;

    cache_state_e        state;
    logic [tag_bits-1:0] tag_arr [num_sets];
    cacheline            data_arr [num_sets];
    logic [num_sets-1:0] valid;

    logic [tag_bits-1:0] tag;
    logic [idx_bits-1:0] index;
    logic [2:0]          word_sel;
    logic                active;
    logic                hit;

    assign tag      = addr[31 -: tag_bits];
    assign index    = addr[offset_bits +: idx_bits];
    assign word_sel = addr[4:2];                      // word within the line.
    assign active   = read && !resp;                  // ignore the held request during resp.
    assign hit      = valid[index] && (tag_arr[index] == tag);

    // only a refill ever reaches memory
    always_comb begin
        mem_req = '0;
        if (state == refill) begin
            mem_req.addr = {addr[31:offset_bits], {offset_bits{1'b0}}};
            mem_req.read = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= lookup;
            valid <= '0;
            resp  <= 1'b0;
        end else begin
            resp <= 1'b0;
            case (state)
                lookup: begin
                    if (active) begin
                        if (hit) begin
                            resp <= 1'b1;
                        end else begin
                            state <= refill;
                        end
                    end
                end
                refill: begin
                    if (mem_resp) begin
                        valid[index] <= 1'b1;
                        state        <= lookup;   // look up again to return the word.
                    end
                end
                default: state <= lookup;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == refill && mem_resp) begin
            tag_arr[index]  <= tag;
            data_arr[index] <= mem_rdata;
        end
        if (state == lookup && active && hit) begin
            rdata <= data_arr[index][{word_sel, 5'b0} +: 32];
        end
    end

endmodule

//--- rtl/cache_arbiter.sv
`timescale 1ns/1ps

module cache_arbiter (
    input  logic                 clk,
    input  logic                 reset,

    input  cache_pkg::line_req_t icache_mem_req,
    output cache_pkg::cacheline  icache_mem_rdata,
    output logic                 icache_mem_resp,

    input  cache_pkg::line_req_t dcache_mem_req,
    output cache_pkg::cacheline  dcache_mem_rdata,
    output logic                 dcache_mem_resp,

    output cache_pkg::line_req_t mem_req,
    input  cache_pkg::cacheline  mem_rdata,
    input  logic                 mem_resp
);
    import cache_pkg::*;

    arb_state_e   state;
    arb_state_e   next_state;
    arb_request_e current_request;
    arb_request_e pending_request;

    // At most one request can be waiting. The owner cannot ask again
    // until its own response, so the other cache is the only candidate.
    always_comb begin
        current_request = none;
        pending_request = none;
        case (state)
            icache: begin
                current_request = iread;            // icache only reads.
                if (dcache_mem_req.read) begin
                    pending_request = dread;
                end else if (dcache_mem_req.write) begin
                    pending_request = dwrite;
                end
            end
            dcache: begin
                if (dcache_mem_req.read) begin
                    current_request = dread;
                end else if (dcache_mem_req.write) begin
                    current_request = dwrite;
                end
                if (icache_mem_req.read) begin
                    pending_request = iread;
                end
            end
            default: ;
        endcase
    end

    // route the memory port to whichever cache owns it
    always_comb begin
        icache_mem_rdata = '0;
        icache_mem_resp  = 1'b0;
        dcache_mem_rdata = '0;
        dcache_mem_resp  = 1'b0;
        mem_req          = '0;
        case (current_request)
            iread: begin
                mem_req.addr     = icache_mem_req.addr;
                mem_req.read     = icache_mem_req.read;
                icache_mem_rdata = mem_rdata;
                icache_mem_resp  = mem_resp;
            end
            dread: begin
                mem_req.addr     = dcache_mem_req.addr;
                mem_req.read     = 1'b1;
                dcache_mem_rdata = mem_rdata;
                dcache_mem_resp  = mem_resp;
            end
            dwrite: begin
                mem_req.addr    = dcache_mem_req.addr;
                mem_req.write   = 1'b1;
                mem_req.data    = dcache_mem_req.data;    // dirty line out.
                dcache_mem_resp = mem_resp;
            end
            default: ;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (icache_mem_req.read) begin
                    next_state = icache;            // icache wins a tie.
                end else if (dcache_mem_req.read || dcache_mem_req.write) begin
                    next_state = dcache;
                end
            end
            icache: begin
                if (mem_resp) begin
                    if (pending_request == dread || pending_request == dwrite) begin
                        next_state = dcache;
                    end else begin
                        next_state = idle;
                    end
                end
            end
            dcache: begin
                if (mem_resp) begin
                    next_state = (pending_request == iread) ? icache : idle;
                end
            end
            default: next_state = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;                          // no memory traffic out of reset.
        end else begin
            state <= next_state;
        end
    end

endmodule

//--- rtl/cache_pkg.sv
package cache_pkg;

    typedef logic [31:0] rv32i_word;           // data or address word.
    typedef logic [255:0] cacheline;           // eight words, 32 bytes.
    typedef logic [3:0] byte_mask;             // one bit per byte lane.

    localparam int offset_bits = 5;            // byte offset within a line.

    // word-wide load/store request from the core side
    typedef struct packed {
        rv32i_word addr;
        logic      read;
        logic      write;
        byte_mask  wmask;                      // lanes written on a store.
        rv32i_word wdata;
    } dcache_req_t;

    // line-wide request toward physical memory
    typedef struct packed {
        rv32i_word addr;                       // always line aligned.
        logic      read;
        logic      write;
        cacheline  data;                       // write-back payload.
    } line_req_t;

    typedef enum logic [1:0] {
        idle,
        icache,
        dcache
    } arb_state_e;

    typedef enum logic [1:0] {
        none,
        iread,
        dread,
        dwrite
    } arb_request_e;

    // shared by both controllers; icache has no use for write_back
    typedef enum logic [1:0] {
        lookup,
        write_back,
        refill
    } cache_state_e;

endpackage
